// File: rtl/basic_pointer_init.sv
/*
 * Sits between the parser and the write FIFO. Passes requests through and,
 * after a program download, queues the twelve BASIC pointer bytes.
 */
`timescale 1ns/100ps

module basic_pointer_init (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  req_wr_i,
	input  memmap_pkg::mem_addr_t req_addr_i,
	input  logic [7:0]            req_data_i,
	input  logic                  prg_done_i,
	input  logic [15:0]           prg_end_i,
	input  logic                  fifo_full_i,
	output logic                  push_o,
	output memmap_pkg::mem_addr_t push_addr_o,
	output logic [7:0]            push_data_o,
	output logic                  inject_done_o
);

	localparam int IDX_W = $clog2(memmap_pkg::PTR_COUNT);

	logic             injecting;
	logic [IDX_W-1:0] ptr_idx;
	logic [15:0]      end_q;
	logic [7:0]       ptr_addr;
	logic [7:0]       ptr_data;
	logic             last_ptr;

	assign ptr_addr = memmap_pkg::ptr_addr_table[ptr_idx];
	assign last_ptr = (ptr_idx == IDX_W'(memmap_pkg::PTR_COUNT - 1));

	// Value per table slot
	// Entries 2..7 and 10..11 alternate low and high byte of the end address
	always_comb begin
		case (ptr_idx)
			IDX_W'(0): ptr_data = memmap_pkg::PTR_TXT_LO;
			IDX_W'(1): ptr_data = memmap_pkg::PTR_TXT_HI;
			IDX_W'(8), IDX_W'(9): ptr_data = memmap_pkg::PTR_SAVE_VAL;
			default: ptr_data = ptr_idx[0] ? end_q[15:8] : end_q[7:0];
		endcase
	end

	// ==============================
	// Push mux
	// ==============================
	always_comb begin
		if (injecting) begin
			push_o      = !fifo_full_i;
			push_addr_o = {17'd0, ptr_addr};
			push_data_o = ptr_data;
		end else begin
			push_o      = req_wr_i;
			push_addr_o = req_addr_i;
			push_data_o = req_data_i;
		end
	end

	// ==============================
	// Injection sequence
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			injecting     <= 1'b0;
			ptr_idx       <= '0;
			inject_done_o <= 1'b0;
		end else begin
			inject_done_o <= 1'b0;
			if (prg_done_i) begin
				injecting <= 1'b1;
				ptr_idx   <= '0;
			end else if (injecting && !fifo_full_i) begin
				if (last_ptr) begin
					injecting     <= 1'b0;
					inject_done_o <= 1'b1;
				end else begin
					ptr_idx <= ptr_idx + 1'b1;
				end
			end
		end
	end

	// End address captured with the done strobe
	always_ff @(posedge clk_sys) begin
		if (prg_done_i) begin
			end_q <= prg_end_i;
		end
	end

endmodule

// File: rtl/download_parser.sv
/*
 * Turns the host download stream into memory write requests.
 * Program files are placed at their load address, tape images in the
 * tape region. Signals the end of a program download once.
 */
`timescale 1ns/100ps

module download_parser (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic                   dl_active_i,
	input  logic                   dl_wr_i,
	input  loader_pkg::file_index_u dl_index_i,
	input  loader_pkg::offset_t    dl_offset_i,
	input  logic [7:0]             dl_data_i,
	output logic                   req_wr_o,
	output memmap_pkg::mem_addr_t  req_addr_o,
	output logic [7:0]             req_data_o,
	output logic                   prg_done_o,
	output logic [15:0]            prg_end_o
);

	logic        is_prg;
	logic        is_tap;
	logic        active_q;
	logic        prg_q;
	logic [15:0] cur_addr;

	// Kind and sub-index through the fields, tape through the raw byte
	assign is_prg = (dl_index_i.fields.kind == loader_pkg::KIND_PRG) &&
	                (dl_index_i.fields.sub_index == 2'd0);
	assign is_tap = (dl_index_i.raw == loader_pkg::INDEX_TAP);

	// Next free address, which is also the end address once done
	assign prg_end_o = cur_addr;

	// ==============================
	// Control
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			req_wr_o   <= 1'b0;
			prg_done_o <= 1'b0;
			active_q   <= 1'b0;
			prg_q      <= 1'b0;
		end else begin
			active_q   <= dl_active_i;
			prg_done_o <= active_q && !dl_active_i && prg_q;
			if (dl_active_i) begin
				prg_q <= is_prg;
			end
			// Header bytes of a program make no request
			req_wr_o <= dl_wr_i && (is_tap ||
			            (is_prg && dl_offset_i >= loader_pkg::PRG_HDR_LEN));
		end
	end

	// ==============================
	// Address and data
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (dl_wr_i) begin
			req_data_o <= dl_data_i;
			if (is_tap) begin
				req_addr_o <= memmap_pkg::TAP_BASE + dl_offset_i;
			end else if (is_prg) begin
				if (dl_offset_i == 25'd0) begin
					cur_addr[7:0] <= dl_data_i;
				end else if (dl_offset_i == 25'd1) begin
					cur_addr[15:8] <= dl_data_i;
				end else begin
					req_addr_o <= {9'd0, cur_addr};
					cur_addr   <= cur_addr + 16'd1;
				end
			end
		end
	end

endmodule

// File: rtl/loader_pkg.sv
/*
 * Host download definitions: the file index byte, the file kinds the
 * loader accepts and the layout of a program file header.
 */
package loader_pkg;

	// ==============================
	// File index from the host menu
	// ==============================

	// Upper bits select a variant of the menu entry and lower bits the kind
	typedef struct packed {
		logic [1:0] sub_index;
		logic [5:0] kind;
	} file_index_s;

	// Same byte seen either as a whole or split in fields
	typedef union packed {
		logic [7:0]  raw;
		file_index_s fields;
	} file_index_u;

	// PRG is kind 4 with sub-index 0
	localparam logic [5:0] KIND_PRG = 6'd4;

	// Tape images use one fixed index value
	localparam logic [7:0] INDEX_TAP = 8'd6;

	// ==============================
	// Program file layout
	// ==============================

	// Header holds the load address with the low byte first
	localparam int PRG_HDR_LEN = 2;

	// Byte offset within the downloaded file
	typedef logic [24:0] offset_t;

endpackage

// File: rtl/mem_slot_writer.sv
/*
 * Drains the write FIFO into memory, one entry per free slot.
 * The slot is the cycle after the computer drops io_cycle_i.
 */
`timescale 1ns/100ps

module mem_slot_writer (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  io_cycle_i,
	input  memmap_pkg::mem_addr_t head_addr_i,
	input  logic [7:0]            head_data_i,
	input  logic                  not_empty_i,
	output logic                  pop_o,
	output logic                  mem_wr_o,
	output memmap_pkg::mem_addr_t mem_addr_o,
	output logic [7:0]            mem_data_o
);

	logic io_cycle_q;
	logic slot;

	// Falling edge of io_cycle_i
	assign slot  = io_cycle_q && !io_cycle_i;
	assign pop_o = slot && not_empty_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_q <= 1'b0;
			mem_wr_o   <= 1'b0;
		end else begin
			io_cycle_q <= io_cycle_i;
			mem_wr_o   <= pop_o;
		end
	end

	// Head entry onto the memory bus together with the write pulse
	always_ff @(posedge clk_sys) begin
		if (pop_o) begin
			mem_addr_o <= head_addr_i;
			mem_data_o <= head_data_i;
		end
	end

endmodule

// File: rtl/memmap_pkg.sv
/*
 * Memory map of the home computer as seen by the download path.
 * Holds the byte address type, the tape region and the BASIC pointer table.
 */
package memmap_pkg;

	// ==============================
	// Address space
	// ==============================

	// Byte address into the shared memory
	typedef logic [24:0] mem_addr_t;

	// Tape images are stored from here upwards
	localparam mem_addr_t TAP_BASE = 25'h200000;

	// ==============================
	// BASIC pointers in page zero
	// ==============================

	// Bytes written after a program load as BASIC LOAD leaves them
	localparam int PTR_COUNT = 12;

	// Written in the order TXT, VAR, ARY, STR, SAVE_START and LOAD_END
	localparam logic [7:0] ptr_addr_table [PTR_COUNT] = '{
		8'h2B, 8'h2C, 8'h2D, 8'h2E,
		8'h2F, 8'h30, 8'h31, 8'h32,
		8'hAC, 8'hAD, 8'hAE, 8'hAF
	};

	// Start of BASIC text as after a cold start
	localparam logic [7:0] PTR_TXT_LO = 8'h01;
	localparam logic [7:0] PTR_TXT_HI = 8'h08;

	// SAVE_START (AC and AD) is left at zero by LOAD
	localparam logic [7:0] PTR_SAVE_VAL = 8'h00;

endpackage

// File: rtl/prg_loader_top.sv
/*
 * File download path: parser and pointer initialiser feed a write FIFO
 * that a slot writer drains into memory. FIFO_DEPTH sizes the buffer.
 */
`timescale 1ns/100ps

module prg_loader_top #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                    clk_sys,
	input  logic                    reset_n,
	input  logic                    dl_active_i,
	input  logic                    dl_wr_i,
	input  loader_pkg::file_index_u dl_index_i,
	input  loader_pkg::offset_t     dl_offset_i,
	input  logic [7:0]              dl_data_i,
	input  logic                    io_cycle_i,
	output logic                    dl_wait_o,
	output logic                    mem_wr_o,
	output memmap_pkg::mem_addr_t   mem_addr_o,
	output logic [7:0]              mem_data_o,
	output logic                    inject_done_o
);

	logic                  req_wr;
	memmap_pkg::mem_addr_t req_addr;
	logic [7:0]            req_data;
	logic                  prg_done;
	logic [15:0]           prg_end;
	logic                  push;
	memmap_pkg::mem_addr_t push_addr;
	logic [7:0]            push_data;
	logic                  fifo_full;
	memmap_pkg::mem_addr_t head_addr;
	logic [7:0]            head_data;
	logic                  not_empty;
	logic                  pop;

	// ==============================
	// Producer
	// ==============================
	download_parser parser0 (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_index_i  (dl_index_i),
		.dl_offset_i (dl_offset_i),
		.dl_data_i   (dl_data_i),
		.req_wr_o    (req_wr),
		.req_addr_o  (req_addr),
		.req_data_o  (req_data),
		.prg_done_o  (prg_done),
		.prg_end_o   (prg_end)
	);

	basic_pointer_init ptr_init0 (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.req_wr_i      (req_wr),
		.req_addr_i    (req_addr),
		.req_data_i    (req_data),
		.prg_done_i    (prg_done),
		.prg_end_i     (prg_end),
		.fifo_full_i   (fifo_full),
		.push_o        (push),
		.push_addr_o   (push_addr),
		.push_data_o   (push_data),
		.inject_done_o (inject_done_o)
	);

	// ==============================
	// Buffer and consumer
	// ==============================
	write_fifo #(
		.DEPTH (FIFO_DEPTH)
	) fifo0 (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.push_i      (push),
		.push_addr_i (push_addr),
		.push_data_i (push_data),
		.pop_i       (pop),
		.head_addr_o (head_addr),
		.head_data_o (head_data),
		.not_empty_o (not_empty),
		.full_o      (fifo_full),
		.dl_wait_o   (dl_wait_o)
	);

	mem_slot_writer writer0 (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.io_cycle_i  (io_cycle_i),
		.head_addr_i (head_addr),
		.head_data_i (head_data),
		.not_empty_i (not_empty),
		.pop_o       (pop),
		.mem_wr_o    (mem_wr_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o)
	);

endmodule

// File: rtl/write_fifo.sv
/*
 * Circular buffer of pending memory writes. Holds requests until the
 * computer leaves a memory slot free and asks the host to wait when
 * nearly full.
 */
`timescale 1ns/100ps

module write_fifo #(
	parameter int DEPTH = 8
) (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  push_i,
	input  memmap_pkg::mem_addr_t push_addr_i,
	input  logic [7:0]            push_data_i,
	input  logic                  pop_i,
	output memmap_pkg::mem_addr_t head_addr_o,
	output logic [7:0]            head_data_o,
	output logic                  not_empty_o,
	output logic                  full_o,
	output logic                  dl_wait_o
);

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	memmap_pkg::mem_addr_t addr_mem [DEPTH];
	logic [7:0]            data_mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && not_empty_o;

	assign head_addr_o = addr_mem[rd_ptr];
	assign head_data_o = data_mem[rd_ptr];
	assign not_empty_o = (count != '0);
	assign full_o      = (count == CW'(DEPTH));

	// Two free places left cover the bytes already on their way
	assign dl_wait_o = (count >= CW'(DEPTH - 2));

	// ==============================
	// Pointers and fill level
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Storage
	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			addr_mem[wr_ptr] <= push_addr_i;
			data_mem[wr_ptr] <= push_data_i;
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the download path testbench with Verilator.
# Exit status is zero only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal \
	--top-module tb_prg_loader \
	--Mdir obj_dir \
	-o sim_prg_loader \
	-f verilog.f \
	&& ./obj_dir/sim_prg_loader > "$LOG" 2>&1

cat "$LOG" 2>/dev/null

grep -qx "Simulation PASSED" "$LOG" && echo "run_sim: pass" && exit 0 \
	|| { echo "run_sim: fail"; exit 1; }

// File: testbench/tb_prg_loader.sv
/*
 * Testbench for the file download path. A table of files is sent through
 * the host port while memory slots come at random, and every memory write
 * is compared with a queue built from the loader rules.
 */
`timescale 1ns/100ps

module tb_prg_loader;

	localparam int NUM_ROWS = 7;

	typedef struct packed {
		logic [7:0]  index;
		logic [15:0] count;
		logic [15:0] base;
		logic [7:0]  data_seed;
	} row_t;

	// Index, data byte count, load address, data seed
	row_t file_table [NUM_ROWS] = '{
		'{8'h04, 16'd20, 16'h0801, 8'h11},
		'{8'h06, 16'd16, 16'h0000, 8'h5A},
		'{8'h44, 16'd6,  16'h1000, 8'h23},
		'{8'h01, 16'd5,  16'h2000, 8'h37},
		'{8'h04, 16'd30, 16'hC000, 8'h7E},
		'{8'h06, 16'd9,  16'h0000, 8'h90},
		'{8'h04, 16'd1,  16'h2000, 8'hC4}
	};

	logic                    clk_sys;
	logic                    reset_n;
	logic                    dl_active_i;
	logic                    dl_wr_i;
	loader_pkg::file_index_u dl_index_i;
	loader_pkg::offset_t     dl_offset_i;
	logic [7:0]              dl_data_i;
	logic                    io_cycle_i;
	logic                    dl_wait_o;
	logic                    mem_wr_o;
	memmap_pkg::mem_addr_t   mem_addr_o;
	logic [7:0]              mem_data_o;
	logic                    inject_done_o;

	integer rand_seed = 32'h3a7e;

	memmap_pkg::mem_addr_t exp_addr [$];
	logic [7:0]            exp_data [$];
	int                    inject_count = 0;

	prg_loader_top #(
		.FIFO_DEPTH (8)
	) dut0 (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.dl_active_i   (dl_active_i),
		.dl_wr_i       (dl_wr_i),
		.dl_index_i    (dl_index_i),
		.dl_offset_i   (dl_offset_i),
		.dl_data_i     (dl_data_i),
		.io_cycle_i    (io_cycle_i),
		.dl_wait_o     (dl_wait_o),
		.mem_wr_o      (mem_wr_o),
		.mem_addr_o    (mem_addr_o),
		.mem_data_o    (mem_data_o),
		.inject_done_o (inject_done_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ==============================
	// Reference model
	// ==============================
	function automatic logic [7:0] data_byte(input logic [7:0] data_seed, input int n);
		return 8'(int'(data_seed) + n * 29 + (n >> 3));
	endfunction

	function automatic logic is_prg_index(input logic [7:0] index);
		loader_pkg::file_index_u idx;
		idx.raw = index;
		return (idx.fields.kind == loader_pkg::KIND_PRG) && (idx.fields.sub_index == 2'd0);
	endfunction

	// Byte n of the file as the host sends it including any PRG header
	function automatic logic [7:0] file_byte(input row_t row, input int n);
		if (!is_prg_index(row.index))
			return data_byte(row.data_seed, n);
		if (n == 0)
			return row.base[7:0];
		if (n == 1)
			return row.base[15:8];
		return data_byte(row.data_seed, n - loader_pkg::PRG_HDR_LEN);
	endfunction

	// Value that BASIC LOAD leaves at a page zero address
	function automatic logic [7:0] pointer_value(input logic [7:0] addr,
	                                             input logic [15:0] end_addr);
		case (addr)
			8'h2B: return memmap_pkg::PTR_TXT_LO;
			8'h2C: return memmap_pkg::PTR_TXT_HI;
			8'hAC, 8'hAD: return 8'h00;
			8'h2D, 8'h2F, 8'h31, 8'hAE: return end_addr[7:0];
			default: return end_addr[15:8];
		endcase
	endfunction

	task automatic add_expected(input row_t row);
		logic [15:0] end_addr;
		logic [7:0]  ptr;
		if (is_prg_index(row.index)) begin
			for (int k = 0; k < int'(row.count); k++) begin
				exp_addr.push_back({9'd0, 16'(int'(row.base) + k)});
				exp_data.push_back(data_byte(row.data_seed, k));
			end
			end_addr = 16'(int'(row.base) + int'(row.count));
			for (int i = 0; i < memmap_pkg::PTR_COUNT; i++) begin
				ptr = memmap_pkg::ptr_addr_table[i];
				exp_addr.push_back({17'd0, ptr});
				exp_data.push_back(pointer_value(ptr, end_addr));
			end
		end else if (row.index == loader_pkg::INDEX_TAP) begin
			for (int k = 0; k < int'(row.count); k++) begin
				exp_addr.push_back(memmap_pkg::TAP_BASE + 25'(k));
				exp_data.push_back(data_byte(row.data_seed, k));
			end
		end
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
	                           input string what);
		if (got !== expected) begin
			$display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
			$display("Simulation FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	// ==============================
	// Host side
	// ==============================
	task automatic send_file(input row_t row);
		int total;
		total = int'(row.count) + (is_prg_index(row.index) ? loader_pkg::PRG_HDR_LEN : 0);
		@(posedge clk_sys);
		dl_index_i.raw <= row.index;
		dl_active_i    <= 1'b1;
		repeat (2) @(posedge clk_sys);
		for (int n = 0; n < total; n++) begin
			@(negedge clk_sys);
			while (dl_wait_o)
				@(negedge clk_sys);
			@(posedge clk_sys);
			dl_wr_i     <= 1'b1;
			dl_offset_i <= 25'(n);
			dl_data_i   <= file_byte(row, n);
			@(posedge clk_sys);
			dl_wr_i <= 1'b0;
		end
		repeat (2) @(posedge clk_sys);
		dl_active_i <= 1'b0;
		// Next file only once the pointer bytes are queued
		if (is_prg_index(row.index)) begin
			@(negedge clk_sys);
			while (!inject_done_o)
				@(negedge clk_sys);
		end
		repeat (3) @(posedge clk_sys);
	endtask

	// Memory slots of random length with a low phase of at least two cycles
	initial begin : slot_gen
		int high_len;
		int low_len;
		forever begin
			high_len = 1 + int'($unsigned($random(rand_seed)) % 8);
			low_len  = 2 + int'($unsigned($random(rand_seed)) % 2);
			@(posedge clk_sys);
			io_cycle_i <= 1'b1;
			repeat (high_len) @(posedge clk_sys);
			io_cycle_i <= 1'b0;
			repeat (low_len - 1) @(posedge clk_sys);
		end
	end

	// ==============================
	// Monitor
	// ==============================
	always @(negedge clk_sys) begin
		if (reset_n) begin
			if (inject_done_o)
				inject_count++;
			if (mem_wr_o) begin
				check_value(32'(io_cycle_i), 32'd0, "io_cycle_i during mem_wr_o");
				if (exp_addr.size() == 0) begin
					$display("Memory write at %0t ns while no write was expected", $time);
					$display("Simulation FAILED");
					$fatal(1, "unexpected write");
				end else begin
					check_value(32'(mem_addr_o), 32'(exp_addr[0]), "mem_addr_o");
					check_value(32'(mem_data_o), 32'(exp_data[0]), "mem_data_o");
					void'(exp_addr.pop_front());
					void'(exp_data.pop_front());
				end
			end
		end
	end

	// Time limit from the table size
	initial begin : watchdog
		int limit;
		limit = 1000;
		for (int r = 0; r < NUM_ROWS; r++)
			limit += 40 * (int'(file_table[r].count) + 14);
		repeat (limit) @(posedge clk_sys);
		$display("Timeout: run did not finish within %0d cycles", limit);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	// ==============================
	// Main sequence
	// ==============================
	initial begin : main_seq
		int prg_rows;
		reset_n     = 1'b0;
		dl_active_i = 1'b0;
		dl_wr_i     = 1'b0;
		dl_index_i  = '0;
		dl_offset_i = '0;
		dl_data_i   = 8'h00;
		io_cycle_i  = 1'b0;
		prg_rows    = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			add_expected(file_table[r]);
			if (is_prg_index(file_table[r].index))
				prg_rows++;
		end

		repeat (16) @(posedge clk_sys);
		reset_n <= 1'b1;
		@(negedge clk_sys);
		check_value(32'(mem_wr_o), 32'd0, "mem_wr_o after reset");
		check_value(32'(dl_wait_o), 32'd0, "dl_wait_o after reset");
		check_value(32'(inject_done_o), 32'd0, "inject_done_o after reset");

		for (int r = 0; r < NUM_ROWS; r++)
			send_file(file_table[r]);

		// Drain and then look for stray writes
		while (exp_addr.size() != 0)
			@(negedge clk_sys);
		repeat (40) @(negedge clk_sys);
		check_value(32'(inject_count), 32'(prg_rows), "inject_done_o pulses");
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: verilog.f
rtl/memmap_pkg.sv
rtl/loader_pkg.sv
rtl/download_parser.sv
rtl/basic_pointer_init.sv
rtl/write_fifo.sv
rtl/mem_slot_writer.sv
rtl/prg_loader_top.sv
testbench/tb_prg_loader.sv
